//--- rtl/CommitPkg.sv
//======================================================================
// Shared definitions for the commit stage
// Widths, APB register map, execution-state, refetch-type and
// phase enums, and the active list entry layout
//======================================================================
package CommitPkg;

    localparam int COMMIT_WIDTH = 4;     // Head ops examined per cycle
    localparam int AL_DEPTH     = 16;
    localparam int AL_INDEX_W   = 4;
    localparam int AL_COUNT_W   = 5;
    localparam int PC_W         = 16;
    localparam int CNT_W        = 32;    // Committed op counter

    // APB register map
    localparam logic [3:0] ADDR_ALLOC     = 4'h0;
    localparam logic [3:0] ADDR_FINISH    = 4'h4;
    localparam logic [3:0] ADDR_STATUS    = 4'h8;
    localparam logic [3:0] ADDR_COMMITTED = 4'hC;

    typedef logic [1:0]            CommitLaneIndex;
    typedef logic [2:0]            CommitLaneCount;    // 0 to COMMIT_WIDTH
    typedef logic [AL_INDEX_W-1:0] AlIndex;
    typedef logic [AL_COUNT_W-1:0] AlCount;
    typedef logic [PC_W-1:0]       Pc;

    typedef enum logic [3:0] {
        EXEC_NOT_FINISHED  = 4'd0,
        EXEC_SUCCESS       = 4'd1,
        EXEC_REFETCH_NEXT  = 4'd2,
        EXEC_REFETCH_THIS  = 4'd3,
        EXEC_TRAP_ECALL    = 4'd4,
        EXEC_TRAP_EBREAK   = 4'd5,
        EXEC_FAULT_LOAD    = 4'd6,
        EXEC_FAULT_STORE   = 4'd7,
        EXEC_FAULT_ILLEGAL = 4'd8
    } ExecState;

    typedef enum logic [2:0] {
        REFETCH_THIS_PC         = 3'd0,
        REFETCH_NEXT_PC         = 3'd1,
        REFETCH_STORE_NEXT_PC   = 3'd2,
        REFETCH_BRANCH_TARGET   = 3'd3,
        REFETCH_NEXT_PC_TO_TRAP = 3'd4,
        REFETCH_THIS_PC_TO_TRAP = 3'd5
    } RefetchType;

    typedef enum logic {
        PHASE_COMMIT  = 1'b0,
        PHASE_RECOVER = 1'b1
    } PipelinePhase;

    typedef struct packed {
        logic     last;        // Final op of its instruction
        logic     isBranch;
        logic     isStore;
        logic     isLoad;
        Pc        pc;
        ExecState execState;
    } ActiveListEntry;

endpackage

//--- rtl/CommitIfs.sv
//======================================================================
// AlHeadIf: active list head window and pop/flush control
// LaneVerdictIf: per-lane recovery verdicts
//======================================================================
`timescale 1ns/1ns

interface AlHeadIf import CommitPkg::*; ();
    ActiveListEntry headEntry [COMMIT_WIDTH];    // Oldest op in lane 0
    AlCount         validEntryNum;
    CommitLaneCount popNum;
    logic           flush;

    modport list    (output headEntry, validEntryNum, input popNum, flush);
    modport lane    (input headEntry, validEntryNum);
    modport decider (input headEntry, validEntryNum, output popNum, flush);
endinterface

interface LaneVerdictIf import CommitPkg::*; ();
    // One element per lane, each written by its own classifier
    logic           recovery      [COMMIT_WIDTH];
    CommitLaneIndex recoveryPoint [COMMIT_WIDTH];
    RefetchType     refetchType   [COMMIT_WIDTH];

    modport lane    (output recovery, recoveryPoint, refetchType);
    modport decider (input recovery, recoveryPoint, refetchType);
endinterface

//--- rtl/CommitApbPort.sv
//======================================================================
// APB slave of the commit stage
// Decodes ALLOC and FINISH writes into one-cycle strobes,
// serves STATUS and COMMITTED reads, forms pslverr
//======================================================================
`timescale 1ns/1ns

module CommitApbPort import CommitPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [3:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             allocValid,
    output ActiveListEntry   allocEntry,
    output logic             finishValid,
    output AlIndex           finishIndex,
    output ExecState         finishState,
    input  logic             full,
    input  logic             finishIndexOk,
    input  AlCount           validEntryNum,
    input  Pc                lastCommittedPc,
    input  logic [CNT_W-1:0] committedTotal
);
    logic        setupPhase;
    logic        accessPhase;
    logic        writeOk;
    logic        readOk;
    logic [31:0] readValue;

    assign setupPhase  = psel && !penable;
    assign accessPhase = psel && penable;
    assign pready      = 1'b1;    // Zero wait states

    // ALLOC payload: flags in 19:16 (last, isBranch, isStore, isLoad), pc in 15:0
    assign allocEntry = '{last:      pwdata[19],
                          isBranch:  pwdata[18],
                          isStore:   pwdata[17],
                          isLoad:    pwdata[16],
                          pc:        pwdata[PC_W-1:0],
                          execState: EXEC_NOT_FINISHED};

    assign finishIndex = pwdata[AL_INDEX_W-1:0];
    assign finishState = ExecState'(pwdata[7:4]);

    assign allocValid  = accessPhase && pwrite && (paddr == ADDR_ALLOC) && !full;
    assign finishValid = accessPhase && pwrite && (paddr == ADDR_FINISH) && finishIndexOk;

    // ALLOC and FINISH are write-only, STATUS and COMMITTED read-only
    always_comb begin
        writeOk   = 1'b0;
        readOk    = 1'b0;
        readValue = '0;
        case (paddr)
            ADDR_ALLOC:  writeOk = !full;
            ADDR_FINISH: writeOk = finishIndexOk;
            ADDR_STATUS: begin
                readOk    = 1'b1;
                readValue = {lastCommittedPc, {(32-PC_W-AL_COUNT_W){1'b0}}, validEntryNum};
            end
            ADDR_COMMITTED: begin
                readOk    = 1'b1;
                readValue = committedTotal;
            end
            default: ;
        endcase
    end

    assign pslverr = accessPhase && (pwrite ? !writeOk : !readOk);

    // Read data captured at the end of the setup phase
    always_ff @(posedge clk) begin
        if (rst) begin
            prdata <= '0;
        end else if (setupPhase && !pwrite) begin
            prdata <= readValue;
        end
    end

endmodule

//--- rtl/ActiveList.sv
//======================================================================
// Active list
// 16-entry circular op buffer in program order with one allocate
// and one finish write per cycle, multi-op pop and full flush
//======================================================================
`timescale 1ns/1ns

module ActiveList import CommitPkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           allocValid,
    input  ActiveListEntry allocEntry,
    input  logic           finishValid,
    input  AlIndex         finishIndex,
    input  ExecState       finishState,
    output logic           full,
    output logic           finishIndexOk,
    AlHeadIf.list          head
);
    ActiveListEntry entries [AL_DEPTH];
    AlIndex         headPtr;
    AlIndex         tailPtr;
    AlCount         count;
    AlIndex         finishOffset;

    assign full = (count == AlCount'(AL_DEPTH));

    // FINISH uses the physical slot number, valid if it lies between head and tail
    assign finishOffset  = finishIndex - headPtr;
    assign finishIndexOk = (AlCount'(finishOffset) < count);

    assign head.validEntryNum = count;

    // Head window, empty lanes read as not finished
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            head.headEntry[i] = entries[headPtr + AlIndex'(i)];
            if (AlCount'(i) >= count) begin
                head.headEntry[i].execState = EXEC_NOT_FINISHED;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (allocValid) begin
                tailPtr <= tailPtr + AlIndex'(1);
            end
            if (head.flush) begin
                // Everything older than the tail is dropped, a same-cycle alloc survives
                headPtr <= tailPtr;
                count   <= AlCount'(allocValid);
            end else begin
                headPtr <= headPtr + AlIndex'(head.popNum);
                count   <= count + AlCount'(allocValid) - AlCount'(head.popNum);
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (allocValid) begin
            entries[tailPtr] <= allocEntry;
        end
        if (finishValid) begin
            entries[finishIndex].execState <= finishState;
        end
    end

endmodule

//--- rtl/CommitLaneClassifier.sv
//======================================================================
// Per-lane recovery classifier
// Finds the bounds of the lane's instruction in the head window and
// maps its execution state to a recovery point and refetch type
//======================================================================
`timescale 1ns/1ns

module CommitLaneClassifier import CommitPkg::*; #(
    parameter int LANE = 0
) (
    AlHeadIf.lane      head,
    LaneVerdictIf.lane verdict
);
    ExecState       state;
    CommitLaneIndex insnHead;    // First op of this instruction
    CommitLaneIndex insnTail;    // Last op, or the window end
    logic           recovery;
    CommitLaneIndex recoveryPoint;
    RefetchType     refetchType;

    assign state = head.headEntry[LANE].execState;

    always_comb begin
        insnHead = '0;
        for (int j = 0; j < LANE; j++) begin
            if (head.headEntry[j].last) begin
                insnHead = CommitLaneIndex'(j + 1);
            end
        end
        // Descending so the nearest last flag wins
        insnTail = CommitLaneIndex'(COMMIT_WIDTH - 1);
        for (int j = COMMIT_WIDTH - 1; j >= LANE; j--) begin
            if (head.headEntry[j].last) begin
                insnTail = CommitLaneIndex'(j);
            end
        end
    end

    always_comb begin
        recovery      = 1'b1;
        recoveryPoint = insnHead;
        refetchType   = REFETCH_THIS_PC;
        case (state)
            EXEC_REFETCH_NEXT: begin
                recoveryPoint = insnTail;
                refetchType   = head.headEntry[LANE].isBranch ? REFETCH_BRANCH_TARGET :
                                head.headEntry[LANE].isStore  ? REFETCH_STORE_NEXT_PC :
                                                                REFETCH_NEXT_PC;
            end
            EXEC_REFETCH_THIS: ;    // Restart at instruction start
            EXEC_TRAP_ECALL, EXEC_TRAP_EBREAK: begin
                recoveryPoint = insnTail;
                refetchType   = REFETCH_NEXT_PC_TO_TRAP;
            end
            EXEC_FAULT_LOAD, EXEC_FAULT_STORE, EXEC_FAULT_ILLEGAL: begin
                refetchType = REFETCH_THIS_PC_TO_TRAP;
            end
            default: recovery = 1'b0;
        endcase
    end

    assign verdict.recovery[LANE]      = recovery;
    assign verdict.recoveryPoint[LANE] = recoveryPoint;
    assign verdict.refetchType[LANE]   = refetchType;

endmodule

//--- rtl/CommitDecider.sv
//======================================================================
// Commit decider
// Finished-instruction range, oldest recovery selection, commit
// vector, pipeline phase, recovery outputs and commit counters
//======================================================================
`timescale 1ns/1ns

module CommitDecider import CommitPkg::*; (
    input  logic             clk,
    input  logic             rst,
    AlHeadIf.decider         head,
    LaneVerdictIf.decider    verdict,
    output CommitLaneCount   commitNum,
    output logic             recoveryValid,
    output RefetchType       recoveryType,
    output ExecState         recoveryCause,
    output Pc                recoveryPc,
    output Pc                lastCommittedPc,
    output logic [CNT_W-1:0] committedTotal
);
    PipelinePhase   phase;
    CommitLaneCount finishedOpNum;
    CommitLaneCount finishedInsnRange;
    CommitLaneCount recoveryStart;
    CommitLaneIndex recoveredLane;
    logic           recoveryTrigger;
    logic           toRecovery;
    logic           commit [COMMIT_WIDTH];
    Pc              commitPc;

    always_comb begin
        // Leading finished ops, cut at the lowest unfinished lane
        finishedOpNum = CommitLaneCount'(COMMIT_WIDTH);
        for (int i = COMMIT_WIDTH - 1; i >= 0; i--) begin
            if (AlCount'(i) >= head.validEntryNum ||
                head.headEntry[i].execState == EXEC_NOT_FINISHED) begin
                finishedOpNum = CommitLaneCount'(i);
            end
        end

        // Only whole instructions, so end after the last finished "last" op
        finishedInsnRange = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (CommitLaneCount'(i) < finishedOpNum && head.headEntry[i].last) begin
                finishedInsnRange = CommitLaneCount'(i + 1);
            end
        end

        // Oldest recovery point wins, strict compare keeps the lowest lane on ties
        recoveryTrigger = 1'b0;
        recoveredLane   = '0;
        recoveryStart   = CommitLaneCount'(COMMIT_WIDTH);
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (CommitLaneCount'(i) < finishedInsnRange && verdict.recovery[i] &&
                CommitLaneCount'(verdict.recoveryPoint[i]) < recoveryStart) begin
                recoveryTrigger = 1'b1;
                recoveredLane   = CommitLaneIndex'(i);
                recoveryStart   = CommitLaneCount'(verdict.recoveryPoint[i]);
            end
        end

        toRecovery = (phase == PHASE_COMMIT) && recoveryTrigger;

        commitNum = '0;
        commitPc  = lastCommittedPc;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (phase != PHASE_COMMIT) begin
                commit[i] = 1'b0;    // Nothing retires while recovering
            end else if (recoveryTrigger) begin
                if (CommitLaneCount'(i) < recoveryStart) begin
                    commit[i] = 1'b1;
                end else if (CommitLaneCount'(i) == recoveryStart) begin
                    // Recovering op decides if its point lane retires
                    commit[i] = !(head.headEntry[recoveredLane].execState inside {
                        EXEC_REFETCH_THIS, EXEC_FAULT_LOAD,
                        EXEC_FAULT_STORE, EXEC_FAULT_ILLEGAL});
                end else begin
                    commit[i] = 1'b0;
                end
            end else begin
                commit[i] = CommitLaneCount'(i) < finishedInsnRange;
            end
            if (commit[i]) begin
                commitNum = commitNum + CommitLaneCount'(1);
                commitPc  = head.headEntry[i].pc;    // Youngest committed op
            end
        end
    end

    assign head.popNum    = commitNum;
    assign head.flush     = toRecovery;
    assign recoveryValid  = (phase == PHASE_RECOVER);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase           <= PHASE_COMMIT;
            committedTotal  <= '0;
            lastCommittedPc <= '0;
        end else begin
            phase           <= toRecovery ? PHASE_RECOVER : PHASE_COMMIT;
            committedTotal  <= committedTotal + CNT_W'(commitNum);
            lastCommittedPc <= commitPc;
        end
    end

    // Recovery report, shown during the PHASE_RECOVER cycle
    always_ff @(posedge clk) begin
        if (toRecovery) begin
            recoveryType  <= verdict.refetchType[recoveredLane];
            recoveryCause <= head.headEntry[recoveredLane].execState;
            recoveryPc    <= head.headEntry[recoveredLane].pc;
        end
    end

endmodule

//--- rtl/CommitStageTop.sv
//======================================================================
// Commit stage top level
// APB port, active list, four lane classifiers and the decider
//======================================================================
`timescale 1ns/1ns

module CommitStageTop import CommitPkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [3:0]     paddr,
    input  logic [31:0]    pwdata,
    output logic [31:0]    prdata,
    output logic           pready,
    output logic           pslverr,
    output CommitLaneCount commitNum,
    output logic           recoveryValid,
    output RefetchType     recoveryType,
    output ExecState       recoveryCause,
    output Pc              recoveryPc
);
    AlHeadIf      head ();
    LaneVerdictIf verdict ();

    logic             allocValid;
    ActiveListEntry   allocEntry;
    logic             finishValid;
    AlIndex           finishIndex;
    ExecState         finishState;
    logic             full;
    logic             finishIndexOk;
    Pc                lastCommittedPc;
    logic [CNT_W-1:0] committedTotal;

    CommitApbPort i_ApbPort (
        .clk, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .allocValid, .allocEntry,
        .finishValid, .finishIndex, .finishState,
        .full, .finishIndexOk,
        .validEntryNum (head.validEntryNum),
        .lastCommittedPc, .committedTotal
    );

    ActiveList i_ActiveList (
        .clk, .rst,
        .allocValid, .allocEntry,
        .finishValid, .finishIndex, .finishState,
        .full, .finishIndexOk,
        .head (head.list)
    );

    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : genLane
        CommitLaneClassifier #(.LANE(i)) i_Lane (
            .head    (head.lane),
            .verdict (verdict.lane)
        );
    end

    CommitDecider i_Decider (
        .clk, .rst,
        .head    (head.decider),
        .verdict (verdict.decider),
        .commitNum, .recoveryValid, .recoveryType, .recoveryCause, .recoveryPc,
        .lastCommittedPc, .committedTotal
    );

endmodule

//--- sim/CommitStageTb.sv
//======================================================================
// Testbench for the commit stage
// Clock and reset, APB driver tasks, active list model with a
// reference commit function, per-cycle comparison and watchdog
//======================================================================
`timescale 1ns/1ns

module CommitStageTb import CommitPkg::*; ();

    localparam int PERIOD       = 8;
    localparam int HALF         = PERIOD / 2;
    localparam int RANDOM_OPS   = 300;
    localparam int DIRECTED_OPS = 150;
    localparam int TOTAL_OPS    = RANDOM_OPS + DIRECTED_OPS;

    // ALLOC flag nibble, bits 19:16 of pwdata
    localparam logic [3:0] FLAG_LAST   = 4'b1000;
    localparam logic [3:0] FLAG_BRANCH = 4'b0100;
    localparam logic [3:0] FLAG_STORE  = 4'b0010;
    localparam logic [3:0] FLAG_LOAD   = 4'b0001;

    typedef struct packed {
        logic [2:0] num;
        logic       rec;
        RefetchType kind;
        ExecState   cause;
        Pc          pc;
    } CommitResult;

    logic           clk = 1'b0;
    logic           rst;
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [3:0]     paddr;
    logic [31:0]    pwdata;
    logic [31:0]    prdata;
    logic           pready;
    logic           pslverr;
    CommitLaneCount commitNum;
    logic           recoveryValid;
    RefetchType     recoveryType;
    ExecState       recoveryCause;
    Pc              recoveryPc;

    // Active list model, slots mirror the physical buffer
    ActiveListEntry mEntry [AL_DEPTH];
    int             mHead;
    int             mTail;
    int             mCount;
    logic [31:0]    mTotal;
    Pc              mLastPc;
    logic           mRecover;    // Model phase is PHASE_RECOVER
    logic           mRecValid;
    RefetchType     mRecType;
    ExecState       mRecCause;
    Pc              mRecPc;
    logic [31:0]    mReadData;

    int seed = 32'hebbb;

    CommitStageTop i_CommitStageTop (.*);

    always #HALF clk = ~clk;

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            stopOnError($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
                                  name, actual, expected));
        end
    endtask

    function automatic int headSlot(input int lane);
        return (mHead + lane) % AL_DEPTH;
    endfunction

    // States that restart at their own instruction and keep it uncommitted
    function automatic logic refetchesItself(input ExecState s);
        return s inside {EXEC_REFETCH_THIS, EXEC_FAULT_LOAD, EXEC_FAULT_STORE,
                         EXEC_FAULT_ILLEGAL};
    endfunction

    function automatic RefetchType kindOf(input ActiveListEntry op);
        case (op.execState)
            EXEC_REFETCH_NEXT: begin
                if (op.isBranch) return REFETCH_BRANCH_TARGET;
                if (op.isStore) return REFETCH_STORE_NEXT_PC;
                return REFETCH_NEXT_PC;
            end
            EXEC_REFETCH_THIS: return REFETCH_THIS_PC;
            EXEC_TRAP_ECALL, EXEC_TRAP_EBREAK: return REFETCH_NEXT_PC_TO_TRAP;
            default: return REFETCH_THIS_PC_TO_TRAP;
        endcase
    endfunction

    // Expected retire result of the model's four oldest ops
    function automatic CommitResult refCommit();
        CommitResult r;
        int          finished;
        int          range;
        int          bestPoint;
        int          bestLane;
        int          start;
        int          stop;
        int          point;
        ExecState    s;
        r = '0;
        if (mRecover) return r;
        finished = 0;
        while (finished < COMMIT_WIDTH && finished < mCount &&
               mEntry[headSlot(finished)].execState != EXEC_NOT_FINISHED) begin
            finished++;
        end
        range = 0;
        for (int i = 0; i < finished; i++) begin
            if (mEntry[headSlot(i)].last) range = i + 1;
        end
        bestPoint = COMMIT_WIDTH;
        bestLane  = -1;
        for (int i = 0; i < range; i++) begin
            s = mEntry[headSlot(i)].execState;
            if (s != EXEC_SUCCESS) begin
                start = 0;
                for (int j = 0; j < i; j++) begin
                    if (mEntry[headSlot(j)].last) start = j + 1;
                end
                stop = i;
                while (!mEntry[headSlot(stop)].last) stop++;
                point = refetchesItself(s) ? start : stop;
                if (point < bestPoint) begin
                    bestPoint = point;
                    bestLane  = i;
                end
            end
        end
        if (bestLane < 0) begin
            r.num = 3'(range);
        end else begin
            // Chosen op decides whether the point lane retires
            s       = mEntry[headSlot(bestLane)].execState;
            r.num   = 3'(bestPoint + (refetchesItself(s) ? 0 : 1));
            r.rec   = 1'b1;
            r.kind  = kindOf(mEntry[headSlot(bestLane)]);
            r.cause = s;
            r.pc    = mEntry[headSlot(bestLane)].pc;
        end
        return r;
    endfunction

    function automatic logic slotValid(input int slot);
        return ((slot - mHead + AL_DEPTH) % AL_DEPTH) < mCount;
    endfunction

    // Compare just before each rising edge, then step the model past it
    always begin : compareModel
        CommitResult exp;
        logic        access;
        logic        writeOk;
        logic        readOk;
        int          doAlloc;
        @(negedge clk);
        #(HALF - 1);
        if (rst) begin
            mHead     = 0;
            mTail     = 0;
            mCount    = 0;
            mTotal    = '0;
            mLastPc   = '0;
            mRecover  = 1'b0;
            mRecValid = 1'b0;
            mReadData = '0;
        end else begin
            exp     = refCommit();
            access  = psel && penable;
            writeOk = (paddr == ADDR_ALLOC && mCount < AL_DEPTH) ||
                      (paddr == ADDR_FINISH && slotValid(pwdata[3:0]));
            readOk  = (paddr == ADDR_STATUS || paddr == ADDR_COMMITTED);
            checkValue("commitNum", commitNum, exp.num);
            checkValue("recoveryValid", recoveryValid, mRecValid);
            if (mRecValid) begin
                checkValue("recoveryType", recoveryType, mRecType);
                checkValue("recoveryCause", recoveryCause, mRecCause);
                checkValue("recoveryPc", recoveryPc, mRecPc);
            end
            checkValue("pready", pready, 1);
            checkValue("pslverr", pslverr, access && (pwrite ? !writeOk : !readOk));
            if (access && !pwrite) checkValue("prdata", prdata, mReadData);
            if (psel && !penable && !pwrite) begin
                mReadData = (paddr == ADDR_STATUS) ? {mLastPc, 11'h0, 5'(mCount)} :
                            (paddr == ADDR_COMMITTED) ? mTotal : 32'h0;
            end
            doAlloc = (access && pwrite && paddr == ADDR_ALLOC && writeOk) ? 1 : 0;
            if (access && pwrite && paddr == ADDR_FINISH && writeOk) begin
                mEntry[pwdata[3:0]].execState = ExecState'(pwdata[7:4]);
            end
            mTotal = mTotal + exp.num;
            if (exp.num != 0) mLastPc = mEntry[headSlot(exp.num - 1)].pc;
            mRecover  = exp.rec;
            mRecValid = exp.rec;
            mRecType  = exp.kind;
            mRecCause = exp.cause;
            mRecPc    = exp.pc;
            if (exp.rec) begin
                mHead  = mTail;    // Whole list flushed
                mCount = doAlloc;
            end else begin
                mHead  = (mHead + exp.num) % AL_DEPTH;
                mCount = mCount + doAlloc - exp.num;
            end
            if (doAlloc != 0) begin
                mEntry[mTail] = {pwdata[19:16], pwdata[15:0], EXEC_NOT_FINISHED};
                mTail = (mTail + 1) % AL_DEPTH;
            end
        end
    end

    task automatic apbTransfer(input logic write, input logic [3:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(HALF - 1);
        while (!pready) begin
            @(negedge clk);
            #(HALF - 1);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data,
                            output logic err);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data,
                           output logic err);
        apbTransfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic allocOp(input Pc pc, input logic [3:0] flags, output AlIndex slot);
        logic err;
        slot = AlIndex'(mTail);
        apbWrite(ADDR_ALLOC, {12'h0, flags, pc}, err);
    endtask

    task automatic finishOp(input AlIndex slot, input ExecState state);
        logic err;
        apbWrite(ADDR_FINISH, {24'h0, state, slot}, err);
    endtask

    task automatic checkEmpty();
        logic [31:0] data;
        logic        err;
        apbRead(ADDR_STATUS, data, err);
        checkValue("validEntryNum", data[4:0], 0);
    endtask

    task automatic waitRecovery();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            #(HALF - 1);
            cycles++;
        end while (recoveryValid !== 1'b1 && cycles < 8);
        if (recoveryValid !== 1'b1) stopOnError("Recovery was not reported within 8 cycles");
    endtask

    // One op before and one after, the middle op ends with the given state
    task automatic recoveryCase(input logic [3:0] flags, input ExecState state, input Pc pc);
        AlIndex pre;
        AlIndex target;
        AlIndex post;
        allocOp(pc - 16'd4, FLAG_LAST, pre);
        allocOp(pc, flags | FLAG_LAST, target);
        allocOp(pc + 16'd4, FLAG_LAST, post);
        finishOp(pre, EXEC_SUCCESS);
        finishOp(post, EXEC_SUCCESS);
        finishOp(target, state);
        waitRecovery();
        checkValue("recoveryPc", recoveryPc, pc);
        checkValue("recoveryCause", recoveryCause, state);
        checkEmpty();
    endtask

    initial begin
        #(TOTAL_OPS * 20 * PERIOD);
        stopOnError("Timeout: the tests did not complete in the allowed time");
    end

    initial begin : mainTest
        AlIndex      slots [AL_DEPTH];
        logic [31:0] data;
        logic        err;
        logic        last;
        int          r;
        int          openOps;
        AlIndex      slot;
        ExecState    state;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Four single-op instructions finished youngest first retire together
        for (int g = 0; g < 2; g++) begin
            for (int i = 0; i < 4; i++) allocOp(Pc'(16'h100 + 16 * g + 4 * i), FLAG_LAST, slots[i]);
            for (int i = 3; i >= 0; i--) finishOp(slots[i], EXEC_SUCCESS);
        end
        apbRead(ADDR_COMMITTED, data, err);
        checkValue("committedTotal", data, 8);
        apbRead(ADDR_STATUS, data, err);
        checkValue("lastCommittedPc", data[31:16], 16'h11c);

        // Three-op instruction held back until its middle op finishes
        allocOp(16'h200, 4'b0000, slots[0]);
        allocOp(16'h202, 4'b0000, slots[1]);
        allocOp(16'h204, FLAG_LAST, slots[2]);
        finishOp(slots[0], EXEC_SUCCESS);
        finishOp(slots[2], EXEC_SUCCESS);
        repeat (3) @(negedge clk);
        finishOp(slots[1], EXEC_SUCCESS);
        checkEmpty();

        recoveryCase(FLAG_BRANCH, EXEC_REFETCH_NEXT, 16'h300);
        recoveryCase(FLAG_STORE, EXEC_REFETCH_NEXT, 16'h320);
        recoveryCase(4'b0000, EXEC_REFETCH_NEXT, 16'h340);
        recoveryCase(4'b0000, EXEC_REFETCH_THIS, 16'h400);
        recoveryCase(FLAG_LOAD, EXEC_FAULT_LOAD, 16'h420);
        recoveryCase(FLAG_STORE, EXEC_FAULT_STORE, 16'h440);
        recoveryCase(4'b0000, EXEC_FAULT_ILLEGAL, 16'h460);
        recoveryCase(4'b0000, EXEC_TRAP_ECALL, 16'h480);
        recoveryCase(4'b0000, EXEC_TRAP_EBREAK, 16'h4a0);

        // Two recoveries, the older point wins
        allocOp(16'h500, FLAG_LAST, slots[0]);
        allocOp(16'h504, FLAG_LAST, slots[1]);
        finishOp(slots[1], EXEC_FAULT_STORE);
        finishOp(slots[0], EXEC_TRAP_EBREAK);
        waitRecovery();
        checkValue("recoveryPc", recoveryPc, 16'h500);
        allocOp(16'h600, 4'b0000, slots[0]);
        allocOp(16'h602, FLAG_LAST, slots[1]);
        finishOp(slots[0], EXEC_REFETCH_NEXT);
        finishOp(slots[1], EXEC_FAULT_ILLEGAL);
        waitRecovery();
        checkValue("recoveryPc", recoveryPc, 16'h602);
        checkValue("recoveryType", recoveryType, REFETCH_THIS_PC_TO_TRAP);

        // Error responses
        for (int i = 0; i < AL_DEPTH; i++) allocOp(Pc'(16'h700 + 4 * i), FLAG_LAST, slots[i]);
        apbWrite(ADDR_ALLOC, {12'h0, FLAG_LAST, 16'h7ff}, err);
        checkValue("pslverr", err, 1);
        apbRead(ADDR_STATUS, data, err);
        checkValue("validEntryNum", data[4:0], AL_DEPTH);
        for (int i = 0; i < AL_DEPTH; i++) finishOp(slots[i], EXEC_SUCCESS);
        checkEmpty();
        apbWrite(ADDR_FINISH, {24'h0, EXEC_SUCCESS, 4'd5}, err);
        checkValue("pslverr", err, 1);
        apbRead(4'h2, data, err);
        checkValue("pslverr", err, 1);
        apbWrite(4'h6, 32'h1234, err);
        checkValue("pslverr", err, 1);
        apbRead(ADDR_ALLOC, data, err);
        checkValue("pslverr", err, 1);
        checkEmpty();

        // Random mix, instructions capped at four ops
        openOps = 0;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $random(seed);
            if (r[15:13] == 3'd0) begin
                apbRead(r[16] ? ADDR_STATUS : ADDR_COMMITTED, data, err);
            end else if (mCount == 0 || (mCount < AL_DEPTH && r[0])) begin
                last = (r[3:1] < 3'd5) || (openOps == 3);
                allocOp(Pc'($random(seed)), {last, r[6:4]}, slot);
                openOps = last ? 0 : openOps + 1;
            end else begin
                if (r[12:10] == 3'd0 && mCount < AL_DEPTH) begin
                    slot = AlIndex'(mTail);    // Just past the tail
                end else begin
                    slot = AlIndex'((mHead + int'(r[23:17]) % mCount) % AL_DEPTH);
                end
                state = (r[9:7] < 3'd5) ? EXEC_SUCCESS : ExecState'(4'd2 + 4'(r[29:24] % 7));
                finishOp(slot, state);
            end
        end
        repeat (4) @(negedge clk);

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- CommitStageTop.f
rtl/CommitPkg.sv
rtl/CommitIfs.sv
rtl/CommitApbPort.sv
rtl/ActiveList.sv
rtl/CommitLaneClassifier.sv
rtl/CommitDecider.sv
rtl/CommitStageTop.sv
sim/CommitStageTb.sv

//--- Bender.yml
package:
  name: commit_stage

sources:
  - rtl/CommitPkg.sv
  - rtl/CommitIfs.sv
  - rtl/CommitApbPort.sv
  - rtl/ActiveList.sv
  - rtl/CommitLaneClassifier.sv
  - rtl/CommitDecider.sv
  - rtl/CommitStageTop.sv
  - target: test
    files:
      - sim/CommitStageTb.sv
